// ==== Bender.yml ====
package:
  name: acq_daq

sources:
  - include_dirs:
      - design
    files:
      - design/daq_types_pkg.sv
      - design/dram_pkg.sv
      - design/buf_rd_if.sv
      - design/trigger_detect.sv
      - design/sample_buffer_bank.sv
      - design/dram_write_ctrl.sv
      - design/acq_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_acq_top.sv

// ==== all.f ====
+incdir+design
design/daq_types_pkg.sv
design/dram_pkg.sv
design/buf_rd_if.sv
design/trigger_detect.sv
design/sample_buffer_bank.sv
design/dram_write_ctrl.sv
design/acq_top.sv
sim/tb_acq_top.sv

// ==== design/acq_top.sv ====
`timescale 1ns/1ps
`include "daq_cfg.svh"

module acq_top
	import daq_types_pkg::*, dram_pkg::*;
(
	input  logic                    avalon_clk,
	input  logic                    rst,
	input  logic [`DAQ_SAMPLE_W-1:0] rx_data_0,   // Receiver 0
	input  logic [`DAQ_SAMPLE_W-1:0] rx_data_1,
	input  logic [`DAQ_SAMPLE_W-1:0] rx_data_2,
	input  logic [`DAQ_SAMPLE_W-1:0] rx_data_3,
	input  logic [`DAQ_SAMPLE_W-1:0] threshold,   // Signed compare level
	input  logic [`DAQ_NUM_CH-1:0]   ch_enable,   // Channels to write out
	output logic                    trig_status,
	output logic                    done,
	// Memory write port
	output logic                    wr_en,
	output logic                    wr_burst_begin,
	output logic [BURST_CNT_W-1:0]  wr_burst_count,
	output logic [`DAQ_ADDR_W-1:0]   wr_addr,
	output logic [63:0]             wr_data,
	input  logic                    wait_request
);

	sample_t rx_samples [`DAQ_NUM_CH];   // Receivers as one array
	tstamp_t trig_tstamp;
	logic    rearm;

	buf_rd_if rd_link ();   // Bank to write controller

	assign rx_samples[0] = rx_data_0;
	assign rx_samples[1] = rx_data_1;
	assign rx_samples[2] = rx_data_2;
	assign rx_samples[3] = rx_data_3;

	////////////////////////////////////////////////////////////
	// Trigger, capture, readout
	////////////////////////////////////////////////////////////
	trigger_detect trig0 (
		.avalon_clk  (avalon_clk),
		.rst         (rst),
		.samples     (rx_samples),
		.threshold   (threshold),
		.rearm       (rearm),
		.trig_status (trig_status),
		.trig_tstamp (trig_tstamp)
	);

	sample_buffer_bank bank0 (
		.avalon_clk  (avalon_clk),
		.rst         (rst),
		.samples     (rx_samples),
		.trig_status (trig_status),   // Capture window
		.rd          (rd_link.bank)
	);

	dram_write_ctrl wctrl0 (
		.avalon_clk     (avalon_clk),
		.rst            (rst),
		.ch_enable      (ch_enable),
		.trig_status    (trig_status),
		.trig_tstamp    (trig_tstamp),
		.rearm          (rearm),
		.done           (done),
		.rd             (rd_link.ctrl),
		.wr_en          (wr_en),
		.wr_burst_begin (wr_burst_begin),
		.wr_burst_count (wr_burst_count),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wait_request   (wait_request)
	);

endmodule

// ==== design/buf_rd_if.sv ====
`timescale 1ns/1ps

interface buf_rd_if
	import daq_types_pkg::*, dram_pkg::*;
();

	ch_mask_t   ready;     // Channel has all words stored
	ch_idx_t    sel;       // Channel being drained
	logic       pop;       // Current word consumed
	dram_word_u rd_data;   // Oldest unread word of sel, registered
	logic       clear;     // Drop everything, event done

	// Write controller side
	modport ctrl (
		input  ready,
		input  rd_data,
		output sel,
		output pop,
		output clear
	);

	// Buffer side
	modport bank (
		input  sel,
		input  pop,
		input  clear,
		output ready,
		output rd_data
	);

endinterface

// ==== design/daq_cfg.svh ====
`ifndef DAQ_CFG_SVH
`define DAQ_CFG_SVH

////////////////////////////////////////////////////////////
// Receiver side
////////////////////////////////////////////////////////////
`define DAQ_NUM_CH        4     // Receiver channels
`define DAQ_SAMPLE_W      16    // Bits per sample

////////////////////////////////////////////////////////////
// Capture sizing
////////////////////////////////////////////////////////////
`define DAQ_CAPTURE_LEN   16    // Samples kept per channel per event
// Four samples share one memory word
`define DAQ_WORDS_PER_CH  (`DAQ_CAPTURE_LEN / 4)

////////////////////////////////////////////////////////////
// Memory side
////////////////////////////////////////////////////////////
`define DAQ_ADDR_W        25    // Word address, 64-bit words

`endif

// ==== design/daq_types_pkg.sv ====
`include "daq_cfg.svh"

package daq_types_pkg;

	// Raw receiver sample, two's complement
	typedef logic signed [`DAQ_SAMPLE_W-1:0] sample_t;

	// Free-running cycle count, wraps silently
	typedef logic [15:0] tstamp_t;

	// Channel number, wide enough for every receiver
	typedef logic [$clog2(`DAQ_NUM_CH)-1:0] ch_idx_t;

	// One bit per receiver, bit 0 is channel 0
	typedef logic [`DAQ_NUM_CH-1:0] ch_mask_t;

endpackage

// ==== design/dram_pkg.sv ====
`include "daq_cfg.svh"

package dram_pkg;

	import daq_types_pkg::*;

	localparam logic [7:0] HDR_TAG = 8'hA5;   // Marks a header word in memory

	// One header word, then the data words of a channel
	localparam int DAQ_BURST_LEN = 1 + `DAQ_WORDS_PER_CH;
	localparam int BURST_CNT_W   = 5;   // Width of the burst count port

	////////////////////////////////////////////////////////////
	// Memory word formats
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [7:0]  tag;         // Always HDR_TAG
		logic [7:0]  channel;     // Receiver number, zero extended
		tstamp_t     tstamp;      // Counter value at the crossing
		logic [15:0] event_num;   // Counts completed events
		logic [15:0] rsvd;        // Written as zero
	} dram_hdr_t;

	// Same 64 bits, seen as header or as four samples
	typedef union packed {
		dram_hdr_t     hdr;
		sample_t [3:0] samples;   // Sample 0 is the oldest, lowest bits
	} dram_word_u;

endpackage

// ==== design/dram_write_ctrl.sv ====
`timescale 1ns/1ps
`include "daq_cfg.svh"

module dram_write_ctrl
	import daq_types_pkg::*, dram_pkg::*;
(
	input  logic                   avalon_clk,
	input  logic                   rst,
	input  ch_mask_t               ch_enable,
	input  logic                   trig_status,
	input  tstamp_t                trig_tstamp,
	output logic                   rearm,   // Back to trigger block
	output logic                   done,    // One pulse per event
	buf_rd_if.ctrl                 rd,
	output logic                   wr_en,
	output logic                   wr_burst_begin,
	output logic [BURST_CNT_W-1:0] wr_burst_count,
	output logic [`DAQ_ADDR_W-1:0] wr_addr,
	output dram_word_u             wr_data,
	input  logic                   wait_request
);

	localparam int BEAT_W = $clog2(`DAQ_WORDS_PER_CH);

	typedef enum logic [2:0] {
		ST_IDLE, ST_WAIT_RDY, ST_SELECT, ST_HEADER, ST_DATA, ST_FINISH
	} state_t;

	state_t            state;
	ch_mask_t          pend;        // Enabled channels not yet written
	ch_idx_t           ch_q;        // Channel in progress
	ch_idx_t           nxt_ch;      // Lowest pending channel
	logic [BEAT_W-1:0] beat;        // Data word within the burst
	logic [15:0]       event_num;
	logic              accept;      // Memory took the word
	dram_word_u        hdr_word;

	assign accept = wr_en && !wait_request;

	// Ascending order, lowest set bit first
	always_comb begin
		nxt_ch = '0;
		for (int i = `DAQ_NUM_CH - 1; i >= 0; i--)
			if (pend[i])
				nxt_ch = ch_idx_t'(i);
	end

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst) begin
			state     <= ST_IDLE;
			pend      <= '0;
			ch_q      <= '0;
			beat      <= '0;
			event_num <= '0;
			wr_addr   <= '0;
		end else begin
			if (accept)
				wr_addr <= wr_addr + 1'b1;   // Runs on across events
			case (state)
				ST_IDLE: if (trig_status) begin
					pend  <= ch_enable;   // Mask fixed for this event
					state <= ST_WAIT_RDY;
				end
				ST_WAIT_RDY: if ((rd.ready & pend) == pend)
					state <= ST_SELECT;
				ST_SELECT: begin
					if (pend == '0) begin
						state <= ST_FINISH;   // Nothing left, or nothing enabled
					end else begin
						ch_q  <= nxt_ch;
						state <= ST_HEADER;
					end
				end
				ST_HEADER: if (accept) begin
					beat  <= '0;
					state <= ST_DATA;
				end
				ST_DATA: if (accept) begin
					beat <= beat + 1'b1;
					if (beat == BEAT_W'(`DAQ_WORDS_PER_CH - 1)) begin
						pend[ch_q] <= 1'b0;   // Channel written out
						state      <= ST_SELECT;
					end
				end
				ST_FINISH: begin
					event_num <= event_num + 1'b1;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Header view of the memory word
	always_comb begin
		hdr_word.hdr.tag       = HDR_TAG;
		hdr_word.hdr.channel   = 8'(ch_q);
		hdr_word.hdr.tstamp    = trig_tstamp;   // Held by trigger block until rearm
		hdr_word.hdr.event_num = event_num;
		hdr_word.hdr.rsvd      = '0;
	end

	////////////////////////////////////////////////////////////
	// Memory port and bank strobes
	////////////////////////////////////////////////////////////
	// All from state and held data, stable under wait_request
	assign wr_en          = (state == ST_HEADER) || (state == ST_DATA);
	assign wr_burst_begin = (state == ST_HEADER);   // First word of the burst
	assign wr_burst_count = wr_en ? BURST_CNT_W'(DAQ_BURST_LEN) : '0;
	assign wr_data        = (state == ST_DATA) ? rd.rd_data : hdr_word;

	assign rd.sel   = ch_q;
	assign rd.pop   = (state == ST_DATA) && accept;   // Only on an accepted data word
	assign rd.clear = (state == ST_FINISH);
	assign done     = (state == ST_FINISH);
	assign rearm    = (state == ST_FINISH);   // Same cycle as done and clear

endmodule

// ==== design/sample_buffer_bank.sv ====
`timescale 1ns/1ps
`include "daq_cfg.svh"

module sample_buffer_bank
	import daq_types_pkg::*, dram_pkg::*;
(
	input  logic    avalon_clk,
	input  logic    rst,
	input  sample_t samples [`DAQ_NUM_CH],
	input  logic    trig_status,   // Capture while high
	buf_rd_if.bank  rd
);

	localparam int CNT_W  = $clog2(`DAQ_CAPTURE_LEN + 1);
	localparam int WIDX_W = $clog2(`DAQ_WORDS_PER_CH);

	logic [CNT_W-1:0]  cnt [`DAQ_NUM_CH];      // Samples taken this event
	logic [WIDX_W-1:0] rd_ptr [`DAQ_NUM_CH];   // Next word to hand out
	sample_t [2:0]     pack [`DAQ_NUM_CH];     // Up to three samples waiting
	dram_word_u        store [`DAQ_NUM_CH][`DAQ_WORDS_PER_CH];
	logic [WIDX_W-1:0] rd_idx;                 // Word index for the mux

	////////////////////////////////////////////////////////////
	// Capture control and read pointers
	////////////////////////////////////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst) begin
			for (int c = 0; c < `DAQ_NUM_CH; c++) begin
				cnt[c]    <= '0;
				rd_ptr[c] <= '0;
			end
		end else if (rd.clear) begin
			for (int c = 0; c < `DAQ_NUM_CH; c++) begin
				cnt[c]    <= '0;   // Empty every channel
				rd_ptr[c] <= '0;
			end
		end else begin
			for (int c = 0; c < `DAQ_NUM_CH; c++)
				if (trig_status && cnt[c] < CNT_W'(`DAQ_CAPTURE_LEN))
					cnt[c] <= cnt[c] + 1'b1;
			if (rd.pop)
				rd_ptr[rd.sel] <= rd_ptr[rd.sel] + 1'b1;
		end
	end

	// Packing and word store, no reset on payload
	always_ff @(posedge avalon_clk) begin
		for (int c = 0; c < `DAQ_NUM_CH; c++) begin
			if (!rd.clear && trig_status && cnt[c] < CNT_W'(`DAQ_CAPTURE_LEN)) begin
				pack[c] <= {samples[c], pack[c][2:1]};   // Newest in at the top
				if (cnt[c][1:0] == 2'd3)   // Fourth sample closes a word
					store[c][cnt[c][WIDX_W+1:2]].samples <= {samples[c], pack[c]};
			end
		end
	end

	// All words of a channel stored, held until clear
	always_comb begin
		for (int c = 0; c < `DAQ_NUM_CH; c++)
			rd.ready[c] = (cnt[c] == CNT_W'(`DAQ_CAPTURE_LEN));
	end

	////////////////////////////////////////////////////////////
	// Registered select mux
	////////////////////////////////////////////////////////////
	// Look one word ahead on pop so data follows a cycle later
	assign rd_idx = rd.pop ? rd_ptr[rd.sel] + 1'b1 : rd_ptr[rd.sel];

	always_ff @(posedge avalon_clk) begin
		rd.rd_data <= store[rd.sel][rd_idx];
	end

endmodule

// ==== design/trigger_detect.sv ====
`timescale 1ns/1ps
`include "daq_cfg.svh"

module trigger_detect
	import daq_types_pkg::*;
(
	input  logic    avalon_clk,
	input  logic    rst,
	input  sample_t samples [`DAQ_NUM_CH],
	input  sample_t threshold,
	input  logic    rearm,         // One cycle, end of readout
	output logic    trig_status,   // Level, held until rearm
	output tstamp_t trig_tstamp    // Counter value of the crossing cycle
);

	tstamp_t tstamp_cnt;   // Free-running
	logic    hit;          // Some channel above threshold this cycle

	// Signed compare, strictly greater
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < `DAQ_NUM_CH; i++)
			if (samples[i] > threshold)
				hit = 1'b1;
	end

	always_ff @(posedge avalon_clk) begin
		if (!rst)
			tstamp_cnt <= '0;
		else
			tstamp_cnt <= tstamp_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Trigger level, first crossing wins
	////////////////////////////////////////////////////////////
	always_ff @(posedge avalon_clk) begin
		if (!rst)
			trig_status <= 1'b0;
		else if (rearm)
			trig_status <= 1'b0;   // Readout finished, look again
		else if (hit)
			trig_status <= 1'b1;   // Stays up through capture and readout
	end

	// Time only taken while armed, so it holds through readout
	always_ff @(posedge avalon_clk) begin
		if (!trig_status && !rearm && hit)
			trig_tstamp <= tstamp_cnt;
	end

endmodule

// ==== sim/tb_acq_top.sv ====
`timescale 1ns/1ps
`include "daq_cfg.svh"

module tb_acq_top
	import dram_pkg::*;
();

	localparam int NUM_ROWS = 6;
	localparam int TIMEOUT  = 2000;   // Cycles allowed for one readout

	typedef struct {
		int       thr;      // Threshold, signed
		bit [3:0] mask;     // ch_enable
		int       quiet;    // Cycles below threshold before the crossing
		int       ch;       // Channel that crosses
		int       stall;    // wait_request chance in percent
		int       bursts;   // Bursts expected for the mask
	} row_t;

	// Event table, one readout per row
	row_t rows [NUM_ROWS] = '{
		'{1000,   4'b1111, 5,  0, 0,  4},
		'{-500,   4'b0101, 12, 3, 30, 2},
		'{20000,  4'b0000, 3,  1, 20, 0},   // Nothing enabled, done only
		'{0,      4'b1000, 7,  2, 60, 1},
		'{12345,  4'b0110, 1,  1, 45, 2},
		'{-20000, 4'b1011, 9,  3, 10, 3}
	};

	logic                    avalon_clk;
	logic                    rst;
	logic [15:0]             rx [`DAQ_NUM_CH];   // Receiver inputs
	logic [15:0]             threshold;
	logic [3:0]              ch_enable;
	logic                    wait_request;
	logic                    trig_status;
	logic                    done;
	logic                    wr_en;
	logic                    wr_burst_begin;
	logic [BURST_CNT_W-1:0]  wr_burst_count;
	logic [`DAQ_ADDR_W-1:0]  wr_addr;
	logic [63:0]             wr_data;

	int                      cycle;      // Same origin as the trigger timestamp
	int                      stall_pct;
	int                      err_cnt;    // Main process errors
	int                      mon_err;    // Monitor errors
	int                      done_cnt;
	logic [15:0]             cap [`DAQ_NUM_CH][`DAQ_CAPTURE_LEN];   // Recorded capture
	logic [63:0]             got_data [$];   // Accepted words
	logic                    got_begin [$];
	logic [BURST_CNT_W-1:0]  got_cnt [$];
	logic [`DAQ_ADDR_W-1:0]  got_addr [$];
	logic                    hold_q;     // Last cycle stalled a write
	logic [BURST_CNT_W+1:0]  prev_ctl;   // wr_en, begin, count
	logic [`DAQ_ADDR_W-1:0]  prev_addr;
	logic [63:0]             prev_data;

	acq_top dut0 (
		.avalon_clk     (avalon_clk),
		.rst            (rst),
		.rx_data_0      (rx[0]),
		.rx_data_1      (rx[1]),
		.rx_data_2      (rx[2]),
		.rx_data_3      (rx[3]),
		.threshold      (threshold),
		.ch_enable      (ch_enable),
		.trig_status    (trig_status),
		.done           (done),
		.wr_en          (wr_en),
		.wr_burst_begin (wr_burst_begin),
		.wr_burst_count (wr_burst_count),
		.wr_addr        (wr_addr),
		.wr_data        (wr_data),
		.wait_request   (wait_request)
	);

	always #20 avalon_clk = ~avalon_clk;   // 40 ns period

	always @(posedge avalon_clk) begin
		if (!rst)
			cycle <= 0;
		else
			cycle <= cycle + 1;   // Counts from 0 after reset release
	end

	function automatic int show_mismatch(string name, logic [63:0] got, logic [63:0] exp);
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
		return 1;
	endfunction

	// Random value strictly below the threshold
	function automatic logic [15:0] quiet_sample(int thr);
		return 16'(thr - 1 - int'($urandom_range(2999, 0)));
	endfunction

	task automatic tick();
		@(posedge avalon_clk);
		wait_request <= ($urandom_range(99, 0) < stall_pct);   // Random stalls
	endtask

	task automatic drive_quiet(int thr);
		for (int c = 0; c < `DAQ_NUM_CH; c++)
			rx[c] <= quiet_sample(thr);
	endtask

	////////////////////////////////////////////////////////////
	// Memory port monitor
	////////////////////////////////////////////////////////////
	always @(posedge avalon_clk) begin : monitor
		int n;
		n = 0;
		if (rst && hold_q) begin   // Write outputs frozen under wait_request
			if (prev_ctl[BURST_CNT_W+1] != wr_en) n += show_mismatch("wr_en", wr_en, 1);
			if (prev_ctl[BURST_CNT_W] != wr_burst_begin)
				n += show_mismatch("wr_burst_begin", wr_burst_begin, prev_ctl[BURST_CNT_W]);
			if (prev_ctl[BURST_CNT_W-1:0] != wr_burst_count)
				n += show_mismatch("wr_burst_count", wr_burst_count, prev_ctl[BURST_CNT_W-1:0]);
			if (prev_addr != wr_addr) n += show_mismatch("wr_addr", wr_addr, prev_addr);
			if (prev_data != wr_data) n += show_mismatch("wr_data", wr_data, prev_data);
		end
		if (rst && wr_en && !wait_request) begin
			got_data.push_back(wr_data);
			got_begin.push_back(wr_burst_begin);
			got_cnt.push_back(wr_burst_count);
			got_addr.push_back(wr_addr);
		end
		if (rst && done)
			done_cnt <= done_cnt + 1;
		mon_err   <= mon_err + n;
		hold_q    <= rst && wr_en && wait_request;
		prev_ctl  <= {wr_en, wr_burst_begin, wr_burst_count};
		prev_addr <= wr_addr;
		prev_data <= wr_data;
	end

	////////////////////////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////////////////////////
	initial begin : stimulus
		int          ev_err;
		int          exp_addr;
		int          n_pass;
		int          n_fail;
		int          tmo;
		logic [15:0] exp_ts;
		logic [63:0] exp_q [$];
		void'($urandom(32'h609f_3d89));
		avalon_clk   = 1'b0;
		rst          = 1'b0;
		threshold    = 16'h7fff;   // Nothing can cross
		ch_enable    = '0;
		wait_request = 1'b0;
		rx           = '{default: '0};
		stall_pct    = 0;
		err_cnt      = 0;
		mon_err      = 0;
		done_cnt     = 0;
		hold_q       = 1'b0;
		exp_addr     = 0;
		n_pass       = 0;
		n_fail       = 0;
		repeat (5) tick();
		rst <= 1'b1;
		for (int ev = 0; ev < NUM_ROWS; ev++) begin
			ev_err    = err_cnt + mon_err;
			stall_pct = rows[ev].stall;
			tick();
			threshold <= 16'(rows[ev].thr);
			ch_enable <= rows[ev].mask;
			drive_quiet(rows[ev].thr);
			repeat (rows[ev].quiet) begin
				tick();
				drive_quiet(rows[ev].thr);
			end
			// Sample equal to the threshold just before the crossing, must not trigger
			rx[rows[ev].ch] <= 16'(rows[ev].thr);
			tick();
			drive_quiet(rows[ev].thr);   // Crossing channel overrides below
			rx[rows[ev].ch] <= 16'(rows[ev].thr + 1 + int'($urandom_range(999, 0)));
			for (int i = 0; i < `DAQ_CAPTURE_LEN; i++) begin
				tick();
				if (i == 0)
					exp_ts = 16'(cycle);   // Cycle that carried the crossing
				if (i == 1 && !trig_status) begin
					$display("trig_status did not rise after the crossing in event %0d", ev);
					err_cnt++;
				end
				for (int c = 0; c < `DAQ_NUM_CH; c++) begin
					// Zero mask keeps inputs quiet, done arrives mid capture
					cap[c][i] = (rows[ev].mask != 0) ? 16'($urandom)
						: quiet_sample(rows[ev].thr);
					rx[c] <= cap[c][i];
				end
			end
			tick();
			drive_quiet(rows[ev].thr);
			tmo = 0;
			while (done_cnt < ev + 1 && tmo < TIMEOUT) begin
				tick();
				tmo++;
			end
			if (tmo >= TIMEOUT) begin
				$display("timeout: no done for event %0d after %0d cycles", ev, TIMEOUT);
				$display("Verification failed");
				$finish;
			end
			tick();
			if (trig_status) begin
				$display("trig_status still high after done in event %0d", ev);
				err_cnt++;
			end
			if (done_cnt != ev + 1) begin
				$display("done pulsed %0d times by event %0d", done_cnt, ev);
				err_cnt++;
			end
			// Model words, header then data oldest first
			exp_q.delete();
			for (int c = 0; c < `DAQ_NUM_CH; c++) begin
				if (rows[ev].mask[c]) begin
					exp_q.push_back({HDR_TAG, 8'(c), exp_ts, 16'(ev), 16'h0000});
					for (int w = 0; w < `DAQ_WORDS_PER_CH; w++)
						exp_q.push_back({cap[c][4*w+3], cap[c][4*w+2], cap[c][4*w+1], cap[c][4*w]});
				end
			end
			if (got_data.size() != rows[ev].bursts * DAQ_BURST_LEN) begin
				$display("event %0d wrote %0d words where %0d were expected", ev,
					got_data.size(), rows[ev].bursts * DAQ_BURST_LEN);
				err_cnt++;
			end
			for (int k = 0; k < got_data.size() && k < exp_q.size(); k++) begin
				if (got_data[k] != exp_q[k])
					err_cnt += show_mismatch("wr_data", got_data[k], exp_q[k]);
				if (got_addr[k] != `DAQ_ADDR_W'(exp_addr + k))
					err_cnt += show_mismatch("wr_addr", got_addr[k], exp_addr + k);
				if (got_begin[k] != (k % DAQ_BURST_LEN == 0))
					err_cnt += show_mismatch("wr_burst_begin", got_begin[k], k % DAQ_BURST_LEN == 0);
				if (got_cnt[k] != BURST_CNT_W'(DAQ_BURST_LEN))
					err_cnt += show_mismatch("wr_burst_count", got_cnt[k], DAQ_BURST_LEN);
			end
			exp_addr += got_data.size();   // Address runs on across events
			got_data.delete();
			got_begin.delete();
			got_cnt.delete();
			got_addr.delete();
			ev_err = err_cnt + mon_err - ev_err;
			if (ev_err == 0)
				n_pass++;
			else
				n_fail++;
			$display("event %0d: %s, mask %b, %0d errors", ev, (ev_err == 0) ? "ok" : "FAIL",
				rows[ev].mask, ev_err);
		end
		tick();
		$display("%0d events, %0d passed, %0d failed, %0d errors", NUM_ROWS, n_pass, n_fail,
			err_cnt + mon_err);
		if (n_fail == 0 && err_cnt + mon_err == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
